/* Makefile */
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= dcache_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= No errors

SOURCES := $(FILELIST) $(wildcard include/*.svh source/*.sv bench/*.sv)
EXE     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(EXE)
	./$(EXE) $(RUN_ARGS) 2>&1 | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/dcache_assert.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_cfg.svh"

module dcache_assert (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      req,
    input logic                      ack,
    input logic [`DCACHE_ADDR_W-1:0] m_araddr,
    input logic                      m_arvalid,
    input logic                      m_arready,
    input logic [`DCACHE_ADDR_W-1:0] m_awaddr,
    input logic                      m_awvalid,
    input logic                      m_awready,
    input logic [`DCACHE_DATA_W-1:0] m_wdata,
    input logic                      m_wvalid,
    input logic                      m_wready,
    input logic                      m_wlast
);

    int fail_count = 0;

    // ==================================================
    // Processor four-phase handshake
    // ==================================================
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> req)
        else begin
            $error("ack rose while req was low");
            fail_count++;
        end

    ack_after_req_low: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(ack) |-> !$past(req))
        else begin
            $error("ack fell before req was low");
            fail_count++;
        end

    // ==================================================
    // Memory channels hold still under back-pressure
    // ==================================================
    ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
        m_arvalid && !m_arready |=> m_arvalid && $stable(m_araddr))
        else begin
            $error("read address channel changed while stalled");
            fail_count++;
        end

    aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
        m_awvalid && !m_awready |=> m_awvalid && $stable(m_awaddr))
        else begin
            $error("write address channel changed while stalled");
            fail_count++;
        end

    w_stable: assert property (@(posedge clk) disable iff (!rst_n)
        m_wvalid && !m_wready |=> m_wvalid && $stable(m_wdata) && $stable(m_wlast))
        else begin
            $error("write data channel changed while stalled");
            fail_count++;
        end

endmodule

bind dcache_top dcache_assert u_dcache_assert (.*);

`default_nettype wire

/* bench/dcache_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_cfg.svh"

module dcache_tb;

    localparam int FIX_N       = 10;
    localparam int RND_PAIRS   = 12;
    localparam int N_OPS       = FIX_N + 2 * RND_PAIRS;
    localparam int CYCLE_LIMIT = N_OPS * 200;

    typedef struct packed {
        logic        we;
        logic [3:0]  be;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [1:0]  exp_fill;    // Value 2 accepts either outcome
        logic [4:0]  exp_wb;      // Value 31 accepts any beat count
    } op_t;

    logic                        clk       = 1'b0;
    logic                        rst_n     = 1'b0;
    logic                        req       = 1'b0;
    logic                        we        = 1'b0;
    logic [`DCACHE_DATA_W/8-1:0] be        = '0;
    logic [`DCACHE_ADDR_W-1:0]   addr      = '0;
    logic [`DCACHE_DATA_W-1:0]   wdata     = '0;
    logic [`DCACHE_DATA_W-1:0]   rdata;
    logic                        ack;
    logic [`DCACHE_ADDR_W-1:0]   m_araddr;
    logic                        m_arvalid;
    logic                        m_arready = 1'b0;
    logic [`DCACHE_DATA_W-1:0]   m_rdata   = '0;
    logic                        m_rvalid  = 1'b0;
    logic                        m_rlast   = 1'b0;
    logic [`DCACHE_ADDR_W-1:0]   m_awaddr;
    logic                        m_awvalid;
    logic                        m_awready = 1'b0;
    logic [`DCACHE_DATA_W-1:0]   m_wdata;
    logic                        m_wvalid;
    logic                        m_wready  = 1'b0;
    logic                        m_wlast;
    logic                        m_bvalid  = 1'b0;

    logic [31:0] lfsr = 32'd91816;
    logic [31:0] ref_mem [logic [31:0]];      // What the processor should see
    logic [31:0] mem_model [logic [31:0]];    // What main memory holds
    op_t         ops [$];
    int          errors      = 0;
    int          ar_cycles   = 0;
    int          wbeat_total = 0;
    int          cycles      = 0;
    logic [31:0] rd_base     = '0;
    logic [3:0]  rd_cnt      = '0;
    logic        rd_active   = 1'b0;
    logic [3:0]  wr_cnt      = '0;
    logic        b_pending   = 1'b0;

    dcache_top u_dcache_top (.*);

    always #4 clk = ~clk;

    // ==================================================
    // Helpers
    // ==================================================
    function automatic logic take_bit();
        logic b;
        b    = lfsr[0];
        lfsr = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'h0);    // Taps 32, 22, 2, 1
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], take_bit()};
        end
        return r;
    endfunction

    function automatic logic [31:0] init_word(input logic [31:0] a);
        return {~a[31:16], a[15:0]};
    endfunction

    function automatic logic [31:0] ref_word(input logic [31:0] a);
        logic [31:0] k;
        k = {a[31:2], 2'b00};
        return ref_mem.exists(k) ? ref_mem[k] : init_word(k);
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] a);
        return mem_model.exists(a) ? mem_model[a] : init_word(a);
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] nw,
                                                input logic [3:0] en);
        logic [31:0] r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (en[b]) begin
                r[8*b +: 8] = nw[8*b +: 8];
            end
        end
        return r;
    endfunction

    function automatic void add_op(input logic w, input logic [3:0] b, input logic [31:0] a,
                                   input logic [31:0] d, input logic [1:0] f,
                                   input logic [4:0] wb);
        ops.push_back(op_t'{w, b, a, d, f, wb});
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    // ==================================================
    // Memory model with random gaps
    // ==================================================
    always @(posedge clk) begin
        if (!rst_n) begin
            m_arready <= 1'b0;
            m_awready <= 1'b0;
            m_wready  <= 1'b0;
            m_rvalid  <= 1'b0;
            m_rlast   <= 1'b0;
            m_bvalid  <= 1'b0;
            rd_active <= 1'b0;
            wr_cnt    <= '0;
            b_pending <= 1'b0;
        end else begin
            m_arready <= take_bit();
            m_awready <= take_bit();
            m_wready  <= take_bit();
            m_bvalid  <= 1'b0;
            m_rvalid  <= 1'b0;
            m_rlast   <= 1'b0;
            if (m_arvalid) begin
                ar_cycles <= ar_cycles + 1;
            end
            if (m_arvalid && m_arready) begin
                rd_base   <= m_araddr;
                rd_cnt    <= '0;
                rd_active <= 1'b1;
            end
            if (rd_active && take_bit()) begin
                m_rvalid <= 1'b1;
                m_rlast  <= (rd_cnt == 4'hF);
                m_rdata  <= model_word({rd_base[31:6], rd_cnt, 2'b00});
                rd_cnt   <= rd_cnt + 4'h1;
                if (rd_cnt == 4'hF) begin
                    rd_active <= 1'b0;
                end
            end
            if (m_wvalid && m_wready) begin
                check("m_wdata", m_wdata, ref_word({m_awaddr[31:6], wr_cnt, 2'b00}));
                check("m_wlast", 32'(m_wlast), 32'(wr_cnt == 4'hF));
                mem_model[{m_awaddr[31:6], wr_cnt, 2'b00}] = m_wdata;
                wr_cnt      <= wr_cnt + 4'h1;
                wbeat_total <= wbeat_total + 1;
                if (wr_cnt == 4'hF) begin
                    b_pending <= 1'b1;
                end
            end
            if (b_pending && take_bit()) begin
                m_bvalid  <= 1'b1;
                b_pending <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the cache stopped answering", cycles);
            $display("Errors found");
            $finish;
        end
    end

    // ==================================================
    // Stimulus table and processor driver
    // ==================================================
    initial begin
        op_t         op;
        logic [31:0] r_tag;
        logic [31:0] r_set;
        logic [31:0] r_ofs;
        logic [31:0] r_be;
        logic [31:0] a;
        int          errs_before;
        int          ar_start;
        int          wb_start;

        add_op(1'b0, 4'h0, 32'h0000_1004, 32'h0, 2'd1, 5'd0);    // Cold miss
        add_op(1'b0, 4'h0, 32'h0000_1010, 32'h0, 2'd0, 5'd0);
        add_op(1'b1, 4'h5, 32'h0000_1010, 32'hAABB_CCDD, 2'd0, 5'd0);
        add_op(1'b0, 4'h0, 32'h0000_1010, 32'h0, 2'd0, 5'd0);
        add_op(1'b1, 4'hF, 32'h0000_2000, 32'h1111_2222, 2'd1, 5'd0);
        add_op(1'b1, 4'hF, 32'h0000_3000, 32'h3333_4444, 2'd1, 5'd0);
        add_op(1'b1, 4'hF, 32'h0000_4000, 32'h5555_6666, 2'd1, 5'd0);
        add_op(1'b1, 4'hF, 32'h0000_5008, 32'h7777_8888, 2'd1, 5'd16);    // Evicts 0x1000
        add_op(1'b0, 4'h0, 32'h0000_1010, 32'h0, 2'd1, 5'd16);
        add_op(1'b0, 4'h0, 32'h0000_5008, 32'h0, 2'd0, 5'd0);
        for (int i = 0; i < RND_PAIRS; i++) begin
            r_tag = rand_bits(3);
            r_set = rand_bits(2);
            r_ofs = rand_bits(4);
            a     = {16'h0000, 5'b01100, r_tag[2:0], r_set[1:0], r_ofs[3:0], 2'b00};
            r_be  = rand_bits(4);
            if (r_be[3:0] == 4'h0) begin
                r_be = 32'hF;
            end
            add_op(1'b1, r_be[3:0], a, rand_bits(32), 2'd2, 5'h1F);
            add_op(1'b0, 4'h0, a, 32'h0, 2'd2, 5'h1F);
        end

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check("ack", 32'(ack), 32'h0);
        check("m_arvalid", 32'(m_arvalid), 32'h0);
        check("m_awvalid", 32'(m_awvalid), 32'h0);
        check("m_wvalid", 32'(m_wvalid), 32'h0);
        check("m_wlast", 32'(m_wlast), 32'h0);
        $display("test reset: %s", (errors == 0) ? "ok" : "mismatch");

        for (int i = 0; i < N_OPS; i++) begin
            op          = ops[i];
            errs_before = errors;
            ar_start    = ar_cycles;
            wb_start    = wbeat_total;
            if (op.we) begin
                ref_mem[{op.addr[31:2], 2'b00}] = merge_bytes(ref_word(op.addr), op.wdata, op.be);
            end
            @(posedge clk);
            req   <= 1'b1;
            we    <= op.we;
            be    <= op.be;
            addr  <= op.addr;
            wdata <= op.wdata;
            do begin
                @(posedge clk);
            end while (!ack);
            req <= 1'b0;
            if (!op.we) begin
                check("rdata", rdata, ref_word(op.addr));
            end
            if (op.exp_fill != 2'd2) begin
                check("m_arvalid seen", 32'(ar_cycles != ar_start), 32'(op.exp_fill));
            end
            if (op.exp_wb != 5'h1F) begin
                check("write beats", 32'(wbeat_total - wb_start), 32'(op.exp_wb));
            end
            do begin
                @(posedge clk);
            end while (ack);
            $display("test %0d %s 0x%h: %s", i, op.we ? "write" : "read", op.addr,
                     (errors == errs_before) ? "ok" : "mismatch");
        end

        errors = errors + u_dcache_top.u_dcache_assert.fail_count;    // Handshake assertions
        $display("%0d tests, %0d failed checks", N_OPS + 1, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dcache_top.f */
+incdir+include
source/dcache_pkg.sv
source/dcache_if.sv
source/tag_store.sv
source/line_store.sv
source/burst_port.sv
source/cache_ctrl.sv
source/dcache_top.sv
bench/dcache_assert.sv
bench/dcache_tb.sv

/* include/dcache_cfg.svh */
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// ==================================================
// Address and data widths
// ==================================================
`define DCACHE_ADDR_W 32
`define DCACHE_DATA_W 32

// ==================================================
// Cache geometry
// ==================================================
`define DCACHE_WORDS  16
`define DCACHE_OFS_W  4
`define DCACHE_SETS   4
`define DCACHE_SET_W  2
`define DCACHE_WAYS   4
`define DCACHE_WAY_W  2

// Whatever is left above set and word offset
`define DCACHE_TAG_W  24

`endif

/* source/burst_port.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_cfg.svh"

module burst_port (
    input  logic                      clk,
    input  logic                      rst_n,
    burst_if.slave                    bu,
    output logic [`DCACHE_ADDR_W-1:0] m_araddr,
    output logic                      m_arvalid,
    input  logic                      m_arready,
    input  logic [`DCACHE_DATA_W-1:0] m_rdata,
    input  logic                      m_rvalid,
    input  logic                      m_rlast,
    output logic [`DCACHE_ADDR_W-1:0] m_awaddr,
    output logic                      m_awvalid,
    input  logic                      m_awready,
    output logic                      m_wvalid,
    input  logic                      m_wready,
    output logic                      m_wlast,
    input  logic                      m_bvalid
);

    logic             rd_busy;
    logic             wr_busy;
    logic             w_prime;
    logic             w_sent;
    logic             wr_done;
    dcache_pkg::ofs_t beat_cnt;
    logic             start;
    logic             w_fire;
    logic             rd_beat;
    logic             b_seen;

    assign start   = bu.bu_start && !rd_busy && !wr_busy;
    assign w_fire  = m_wvalid && m_wready;
    assign rd_beat = rd_busy && m_rvalid;
    assign b_seen  = wr_busy && w_sent && m_bvalid;

    always_ff @(posedge clk) begin
        if (start && bu.bu_write) m_awaddr <= bu.bu_line_addr;
        if (start && !bu.bu_write) m_araddr <= bu.bu_line_addr;
    end

    // ==================================================
    // Channel flags and beat counting
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_busy   <= 1'b0;
            wr_busy   <= 1'b0;
            w_prime   <= 1'b0;
            w_sent    <= 1'b0;
            wr_done   <= 1'b0;
            beat_cnt  <= '0;
            m_arvalid <= 1'b0;
            m_awvalid <= 1'b0;
            m_wvalid  <= 1'b0;
            m_wlast   <= 1'b0;
        end else begin
            wr_done <= b_seen;
            if (start) begin
                beat_cnt <= '0;
                if (bu.bu_write) begin
                    wr_busy   <= 1'b1;
                    w_prime   <= 1'b1;    // One cycle for the first word to come out
                    m_awvalid <= 1'b1;
                end else begin
                    rd_busy   <= 1'b1;
                    m_arvalid <= 1'b1;
                end
            end
            if (m_arvalid && m_arready) m_arvalid <= 1'b0;
            if (m_awvalid && m_awready) m_awvalid <= 1'b0;
            if (w_prime) begin
                w_prime  <= 1'b0;
                m_wvalid <= 1'b1;
            end
            if (w_fire) begin
                beat_cnt <= beat_cnt + 1'b1;
                m_wlast  <= (beat_cnt == dcache_pkg::ofs_t'(`DCACHE_WORDS - 2));
                if (m_wlast) begin
                    m_wvalid <= 1'b0;
                    w_sent   <= 1'b1;
                end
            end
            if (rd_beat) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (m_rlast) rd_busy <= 1'b0;
            end
            if (b_seen) begin
                wr_busy <= 1'b0;
                w_sent  <= 1'b0;
            end
        end
    end

    assign bu.bu_done       = wr_done || (rd_beat && m_rlast);
    assign bu.bu_beat       = m_rdata;
    assign bu.bu_beat_valid = rd_beat || (wr_busy && !w_sent);
    // Look one word ahead on an accepted write beat so the next word is ready in time
    assign bu.bu_ofs        = beat_cnt + dcache_pkg::ofs_t'(w_fire);

endmodule

`default_nettype wire

/* source/cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_cfg.svh"

module cache_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req,
    input  logic                     we,
    input  dcache_pkg::be_t          be,
    input  logic [`DCACHE_ADDR_W-1:0] addr,
    input  dcache_pkg::word_t        wdata,
    output dcache_pkg::word_t        rdata,
    output logic                     ack,
    lookup_if.master                 lk,
    burst_if.master                  bu,
    output dcache_pkg::way_t         ls_way,
    output logic [`DCACHE_SET_W-1:0] ls_set,
    output dcache_pkg::ofs_t         ls_ofs,
    output dcache_pkg::be_t          ls_be,
    output dcache_pkg::word_t        ls_wdata,
    output logic                     ls_we,
    input  dcache_pkg::word_t        ls_rdata
);

    dcache_pkg::ctrl_state_t state;
    dcache_pkg::addr_split_t addr_q;
    logic                    we_q;
    dcache_pkg::be_t         be_q;
    dcache_pkg::word_t       wdata_q;
    logic                    is_write;
    logic                    wb_sel;
    logic                    in_burst;
    dcache_pkg::addr_split_t req_line;
    dcache_pkg::addr_split_t victim_line;

    assign is_write = we_q & (|be_q);    // Zero byte enables make it a read

    always_ff @(posedge clk) begin
        if (state == dcache_pkg::st_idle && req) begin
            addr_q  <= addr;
            we_q    <= we;
            be_q    <= be;
            wdata_q <= wdata;
        end
        if (state == dcache_pkg::st_respond && !is_write) begin
            rdata <= ls_rdata;
        end
    end

    // ==================================================
    // Request sequencing and four-phase handshake
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= dcache_pkg::st_idle;
            ack   <= 1'b0;
        end else begin
            case (state)
                dcache_pkg::st_idle: if (req) state <= dcache_pkg::st_lookup;
                dcache_pkg::st_lookup: begin
                    if (lk.lk_hit)
                        state <= dcache_pkg::st_access;
                    else if (lk.lk_victim_dirty)
                        state <= dcache_pkg::st_writeback;
                    else
                        state <= dcache_pkg::st_fill;
                end
                dcache_pkg::st_writeback: if (bu.bu_done) state <= dcache_pkg::st_fill;
                dcache_pkg::st_fill:      if (bu.bu_done) state <= dcache_pkg::st_install;
                dcache_pkg::st_install:   state <= dcache_pkg::st_lookup;    // Retried as a hit
                dcache_pkg::st_access:    state <= dcache_pkg::st_respond;
                dcache_pkg::st_respond: begin
                    ack   <= 1'b1;
                    state <= dcache_pkg::st_release;
                end
                dcache_pkg::st_release: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= dcache_pkg::st_idle;
                    end
                end
                default: state <= dcache_pkg::st_idle;
            endcase
        end
    end

    // ==================================================
    // Tag store, burst and data array controls
    // ==================================================
    always_comb begin
        req_line        = addr_q;
        req_line.ofs    = '0;
        req_line.bsel   = '0;
        victim_line     = req_line;
        victim_line.tag = lk.lk_victim_tag;
    end

    assign lk.lk_tag        = addr_q.tag;
    assign lk.lk_set        = addr_q.set;
    assign lk.lk_fill       = (state == dcache_pkg::st_install);
    assign lk.lk_advance    = (state == dcache_pkg::st_install);
    assign lk.lk_mark_dirty = (state == dcache_pkg::st_access) && is_write;

    // The fill after a write-back starts in the cycle the write burst reports done
    assign wb_sel          = (state == dcache_pkg::st_lookup) && lk.lk_victim_dirty;
    assign bu.bu_start     = ((state == dcache_pkg::st_lookup) && !lk.lk_hit) ||
                             ((state == dcache_pkg::st_writeback) && bu.bu_done);
    assign bu.bu_write     = wb_sel;
    assign bu.bu_line_addr = wb_sel ? victim_line : req_line;

    assign in_burst = (state == dcache_pkg::st_writeback) || (state == dcache_pkg::st_fill);
    assign ls_way   = lk.lk_way;
    assign ls_set   = addr_q.set;
    assign ls_ofs   = in_burst ? bu.bu_ofs : addr_q.ofs;
    assign ls_be    = (state == dcache_pkg::st_fill) ? '1 : be_q;
    assign ls_wdata = (state == dcache_pkg::st_fill) ? bu.bu_beat : wdata_q;
    assign ls_we    = ((state == dcache_pkg::st_fill) && bu.bu_beat_valid) ||
                      ((state == dcache_pkg::st_access) && is_write);

endmodule

`default_nettype wire

/* source/dcache_if.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_cfg.svh"

interface lookup_if;
    dcache_pkg::tag_t         lk_tag;
    logic [`DCACHE_SET_W-1:0] lk_set;
    logic                     lk_fill;
    logic                     lk_mark_dirty;
    logic                     lk_advance;
    logic                     lk_hit;
    dcache_pkg::way_t         lk_way;           // Hit way, or the victim on a miss
    logic                     lk_victim_dirty;
    dcache_pkg::tag_t         lk_victim_tag;

    modport master (output lk_tag, lk_set, lk_fill, lk_mark_dirty, lk_advance,
                    input  lk_hit, lk_way, lk_victim_dirty, lk_victim_tag);
    modport slave  (input  lk_tag, lk_set, lk_fill, lk_mark_dirty, lk_advance,
                    output lk_hit, lk_way, lk_victim_dirty, lk_victim_tag);
endinterface

interface burst_if;
    logic                      bu_start;
    logic                      bu_write;
    logic [`DCACHE_ADDR_W-1:0] bu_line_addr;
    logic                      bu_done;
    dcache_pkg::word_t         bu_beat;
    logic                      bu_beat_valid;
    dcache_pkg::ofs_t          bu_ofs;          // Word offset of the current beat

    modport master (output bu_start, bu_write, bu_line_addr,
                    input  bu_done, bu_beat, bu_beat_valid, bu_ofs);
    modport slave  (input  bu_start, bu_write, bu_line_addr,
                    output bu_done, bu_beat, bu_beat_valid, bu_ofs);
endinterface

`default_nettype wire

/* source/dcache_pkg.sv */
`default_nettype none
`include "dcache_cfg.svh"

package dcache_pkg;

    typedef logic [`DCACHE_TAG_W-1:0]    tag_t;
    typedef logic [`DCACHE_WAY_W-1:0]    way_t;
    typedef logic [`DCACHE_OFS_W-1:0]    ofs_t;
    typedef logic [`DCACHE_DATA_W-1:0]   word_t;
    typedef logic [`DCACHE_DATA_W/8-1:0] be_t;

    typedef struct packed {
        tag_t                     tag;
        logic [`DCACHE_SET_W-1:0] set;
        ofs_t                     ofs;
        logic [1:0]               bsel;    // Byte within the word
    } addr_split_t;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_access,
        st_writeback,    // Dirty victim goes out first
        st_fill,
        st_install,
        st_respond,
        st_release       // Waiting for req to fall
    } ctrl_state_t;

endpackage

`default_nettype wire

/* source/dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_cfg.svh"

module dcache_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req,
    input  logic                        we,
    input  logic [`DCACHE_DATA_W/8-1:0] be,
    input  logic [`DCACHE_ADDR_W-1:0]   addr,
    input  logic [`DCACHE_DATA_W-1:0]   wdata,
    output logic [`DCACHE_DATA_W-1:0]   rdata,
    output logic                        ack,
    output logic [`DCACHE_ADDR_W-1:0]   m_araddr,
    output logic                        m_arvalid,
    input  logic                        m_arready,
    input  logic [`DCACHE_DATA_W-1:0]   m_rdata,
    input  logic                        m_rvalid,
    input  logic                        m_rlast,
    output logic [`DCACHE_ADDR_W-1:0]   m_awaddr,
    output logic                        m_awvalid,
    input  logic                        m_awready,
    output logic [`DCACHE_DATA_W-1:0]   m_wdata,
    output logic                        m_wvalid,
    input  logic                        m_wready,
    output logic                        m_wlast,
    input  logic                        m_bvalid
);

    lookup_if u_lookup_if ();
    burst_if  u_burst_if ();

    logic [`DCACHE_WAY_W-1:0]   ls_way;
    logic [`DCACHE_SET_W-1:0]   ls_set;
    logic [`DCACHE_OFS_W-1:0]   ls_ofs;
    logic [`DCACHE_DATA_W/8-1:0] ls_be;
    logic [`DCACHE_DATA_W-1:0]  ls_wdata;
    logic                       ls_we;
    logic [`DCACHE_DATA_W-1:0]  ls_rdata;

    cache_ctrl u_cache_ctrl (
        .clk, .rst_n, .req, .we, .be, .addr, .wdata, .rdata, .ack,
        .lk       (u_lookup_if.master),
        .bu       (u_burst_if.master),
        .ls_way, .ls_set, .ls_ofs, .ls_be, .ls_wdata, .ls_we, .ls_rdata
    );

    tag_store u_tag_store (.clk, .rst_n, .lk(u_lookup_if.slave));

    line_store u_line_store (
        .clk, .ls_way, .ls_set, .ls_ofs, .ls_be, .ls_wdata, .ls_we, .ls_rdata
    );

    burst_port u_burst_port (
        .clk, .rst_n,
        .bu       (u_burst_if.slave),
        .m_araddr, .m_arvalid, .m_arready, .m_rdata, .m_rvalid, .m_rlast,
        .m_awaddr, .m_awvalid, .m_awready, .m_wvalid, .m_wready, .m_wlast,
        .m_bvalid
    );

    assign m_wdata = ls_rdata;    // Write-back words come straight off the data array

endmodule

`default_nettype wire

/* source/line_store.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_cfg.svh"

module line_store (
    input  logic                     clk,
    input  dcache_pkg::way_t         ls_way,
    input  logic [`DCACHE_SET_W-1:0] ls_set,
    input  dcache_pkg::ofs_t         ls_ofs,
    input  dcache_pkg::be_t          ls_be,
    input  dcache_pkg::word_t        ls_wdata,
    input  logic                     ls_we,
    output dcache_pkg::word_t        ls_rdata
);

    localparam int DEPTH = `DCACHE_WAYS * `DCACHE_SETS * `DCACHE_WORDS;

    dcache_pkg::word_t        mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] idx;

    // One line per way and set, words laid out in address order
    assign idx = {ls_way, ls_set, ls_ofs};

    always_ff @(posedge clk) begin
        if (ls_we) begin
            for (int b = 0; b < `DCACHE_DATA_W / 8; b++) begin
                if (ls_be[b]) begin
                    mem[idx][8*b +: 8] <= ls_wdata[8*b +: 8];
                end
            end
        end
        ls_rdata <= mem[idx];    // Old contents on a same-cycle write
    end

endmodule

`default_nettype wire

/* source/tag_store.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_cfg.svh"

module tag_store (
    input  logic    clk,
    input  logic    rst_n,
    lookup_if.slave lk
);

    dcache_pkg::tag_t        tags [`DCACHE_SETS][`DCACHE_WAYS];
    logic [`DCACHE_WAYS-1:0] valid [`DCACHE_SETS];
    logic [`DCACHE_WAYS-1:0] dirty [`DCACHE_SETS];
    dcache_pkg::way_t        fifo_ptr [`DCACHE_SETS];    // Oldest way of each set
    logic                    hit;
    dcache_pkg::way_t        hit_way;
    dcache_pkg::way_t        victim;

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (valid[lk.lk_set][w] && tags[lk.lk_set][w] == lk.lk_tag) begin
                hit     = 1'b1;
                hit_way = dcache_pkg::way_t'(w);
            end
        end
    end

    assign victim             = fifo_ptr[lk.lk_set];
    assign lk.lk_hit          = hit;
    assign lk.lk_way          = hit ? hit_way : victim;
    assign lk.lk_victim_dirty = valid[lk.lk_set][victim] && dirty[lk.lk_set][victim];
    assign lk.lk_victim_tag   = tags[lk.lk_set][victim];

    always_ff @(posedge clk) begin
        if (lk.lk_fill) begin
            tags[lk.lk_set][victim] <= lk.lk_tag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `DCACHE_SETS; s++) begin
                valid[s]    <= '0;
                dirty[s]    <= '0;
                fifo_ptr[s] <= '0;
            end
        end else begin
            if (lk.lk_fill) begin
                valid[lk.lk_set][victim] <= 1'b1;
                dirty[lk.lk_set][victim] <= 1'b0;    // A fresh line matches memory
            end
            if (lk.lk_mark_dirty) begin
                dirty[lk.lk_set][hit_way] <= 1'b1;
            end
            if (lk.lk_advance) begin
                fifo_ptr[lk.lk_set] <= fifo_ptr[lk.lk_set] + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire
